// ==== Makefile ====
SIM    = verilator
TOP    = tb_jf_io
FLIST  = junofirst_io.f
OBJDIR = obj_dir
FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FLIST) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

clean:
	rm -rf $(OBJDIR)

// ==== junofirst_io.f ====
+incdir+tb
source/jf_pkg.sv
source/player_controls.sv
source/dip_switch_loader.sv
source/video_output.sv
source/pll_underclock_seq.sv
source/jf_io_top.sv
tb/tb_jf_io.sv

// ==== source/dip_switch_loader.sv ====
// DIP switch loader: captures DIP bytes 0 and 1 from the download stream
module dip_switch_loader (
	input  logic           CLK_49M,
	input  logic           rst_n,
	input  jf_pkg::ioctl_t ioctl,
	output jf_pkg::dip_t   dip_sw
);
	import jf_pkg::*;

	// Stored DIP bytes as downloaded
	// Byte 1 sits in the upper half
	dip_t dip_q;
	logic dip_hit;

	// Write to slot 0 or 1 of the DIP index
	assign dip_hit = ioctl.wr && (ioctl.index == DIP_INDEX)
		&& (ioctl.addr[24:1] == '0);

	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			// Cleared store reads back as all switches open
			dip_q <= '0;
		end else if (dip_hit) begin
			if (ioctl.addr[0]) begin
				dip_q[15:8] <= ioctl.dout;
			end else begin
				dip_q[7:0] <= ioctl.dout;
			end
		end
	end

	// Downloaded bytes are active low
	assign dip_sw = ~dip_q;

endmodule

// ==== source/jf_io_top.sv ====
// Juno First I/O top: splits the status word and connects keys, DIP, video and PLL blocks
module jf_io_top (
	input  logic                CLK_49M,
	input  logic                rst_n,
	input  jf_pkg::ps2_key_t    ps2_key,
	input  jf_pkg::joy_t        joystick_0,
	input  jf_pkg::joy_t        joystick_1,
	input  jf_pkg::ioctl_t      ioctl,
	input  jf_pkg::status_t     status,
	input  jf_pkg::core_video_t core_video,
	input  logic                pll_waitrequest,
	output jf_pkg::cabinet_t    cabinet,
	output jf_pkg::dip_t        dip_sw,
	output jf_pkg::vga_t        vga,
	output logic [12:0]         video_arx,
	output logic [12:0]         video_ary,
	output jf_pkg::pll_cfg_t    pll_cfg
);

	// Status fields used here
	logic [1:0] ar_sel;
	logic       horizontal;
	logic       underclock;

	assign ar_sel     = status[14:13];
	assign horizontal = status[12];
	assign underclock = status[21];

	// ====================================================================
	// Blocks
	// ====================================================================
	player_controls player_controls_i (
		.CLK_49M    (CLK_49M),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cabinet    (cabinet)
	);

	dip_switch_loader dip_switch_loader_i (
		.CLK_49M (CLK_49M),
		.rst_n   (rst_n),
		.ioctl   (ioctl),
		.dip_sw  (dip_sw)
	);

	video_output video_output_i (
		.CLK_49M    (CLK_49M),
		.rst_n      (rst_n),
		.core_video (core_video),
		.ar_sel     (ar_sel),
		.horizontal (horizontal),
		.vga        (vga),
		.video_arx  (video_arx),
		.video_ary  (video_ary)
	);

	// Underclock request comes straight from the OSD bit
	pll_underclock_seq pll_underclock_seq_i (
		.CLK_49M     (CLK_49M),
		.rst_n       (rst_n),
		.underclock  (underclock),
		.waitrequest (pll_waitrequest),
		.cfg         (pll_cfg)
	);

endmodule

// ==== source/jf_pkg.sv ====
// Juno First I/O package with shared widths, types, key codes and PLL constants
package jf_pkg;

	// ====================================================================
	// Plain vector types
	// ====================================================================
	typedef logic [4:0]  chan5_t;
	typedef logic [7:0]  chan8_t;
	typedef logic [7:0]  scancode_t;
	typedef logic [5:0]  pll_addr_t;
	typedef logic [31:0] pll_data_t;
	typedef logic [11:0] aspect_t;
	typedef logic [10:0] ps2_key_t;
	typedef logic [15:0] joy_t;
	typedef logic [31:0] status_t;
	// Byte 1 over byte 0
	typedef logic [15:0] dip_t;

	// PCB-matched tone weights, they add up to FFh
	localparam chan8_t COLOR_W0 = 8'h19;
	localparam chan8_t COLOR_W1 = 8'h24;
	localparam chan8_t COLOR_W2 = 8'h35;
	localparam chan8_t COLOR_W3 = 8'h40;
	localparam chan8_t COLOR_W4 = 8'h4D;

	// Framework key word fields
	localparam int PS2_TOGGLE  = 10;
	localparam int PS2_PRESSED = 9;

	// Scancodes of the keys in use
	localparam scancode_t KEY_START1  = 8'h16;
	localparam scancode_t KEY_START2  = 8'h1E;
	localparam scancode_t KEY_COIN1   = 8'h2E;
	localparam scancode_t KEY_COIN2   = 8'h36;
	localparam scancode_t KEY_SERVICE = 8'h46;
	localparam scancode_t KEY_UP      = 8'h75;
	localparam scancode_t KEY_DOWN    = 8'h72;
	localparam scancode_t KEY_LEFT    = 8'h6B;
	localparam scancode_t KEY_RIGHT   = 8'h74;
	localparam scancode_t KEY_FIRE    = 8'h14;
	localparam scancode_t KEY_WARP    = 8'h11;

	// Joystick word bit positions
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_WARP   = 5;
	localparam int JOY_START  = 6;
	localparam int JOY_R      = 7;
	localparam int JOY_SELECT = 8;

	// ====================================================================
	// Structs
	// ====================================================================
	typedef struct packed {
		logic warp;
		logic fire;
		logic right;
		logic left;
		logic down;
		logic up;
	} stick_t;

	// All cabinet fields are active low
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		stick_t     p1;
		stick_t     p2;
		logic       service;
	} cabinet_t;

	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	typedef struct packed {
		chan5_t r;
		chan5_t g;
		chan5_t b;
		logic   hs;
		logic   vs;
		logic   hblank;
		logic   vblank;
	} core_video_t;

	typedef struct packed {
		chan8_t r;
		chan8_t g;
		chan8_t b;
		logic   hs;
		logic   vs;
		logic   hblank;
		logic   vblank;
	} vga_t;

	typedef struct packed {
		logic      write;
		pll_addr_t address;
		pll_data_t data;
	} pll_cfg_t;

	// Underclock sequence steps, writes go out at 1, 5 and 7
	typedef enum logic [2:0] {
		SEQ_IDLE  = 3'd0,
		SEQ_MODE  = 3'd1,
		SEQ_WAIT2 = 3'd2,
		SEQ_WAIT3 = 3'd3,
		SEQ_WAIT4 = 3'd4,
		SEQ_MVAL  = 3'd5,
		SEQ_WAIT6 = 3'd6,
		SEQ_START = 3'd7
	} seq_state_t;

	// ====================================================================
	// Download, PLL and aspect constants
	// ====================================================================
	localparam logic [7:0] DIP_INDEX      = 8'd254;
	localparam pll_data_t  PLL_M_NATIVE   = 32'd3639383488;
	localparam pll_data_t  PLL_M_UNDER    = 32'd3268298314;
	localparam pll_addr_t  PLL_ADDR_MODE  = 6'd0;
	localparam pll_addr_t  PLL_ADDR_M     = 6'd7;
	localparam pll_addr_t  PLL_ADDR_START = 6'd2;
	localparam aspect_t    AR_NATIVE_W    = 12'd14;
	localparam aspect_t    AR_NATIVE_H    = 12'd16;

endpackage

// ==== source/player_controls.sv ====
// Player controls: decodes PS/2 keys and merges them with joysticks into cabinet inputs
module player_controls (
	input  logic             CLK_49M,
	input  logic             rst_n,
	input  jf_pkg::ps2_key_t ps2_key,
	input  jf_pkg::joy_t     joystick_0,
	input  jf_pkg::joy_t     joystick_1,
	output jf_pkg::cabinet_t cabinet
);
	import jf_pkg::*;

	// Previous toggle bit for key event detection
	logic      toggle_q;
	logic      key_event;
	logic      pressed;
	scancode_t code;

	// Keyboard button levels, high while held
	stick_t key_stick;
	logic   key_start1;
	logic   key_start2;
	logic   key_coin1;
	logic   key_coin2;
	logic   key_service;

	// Joystick word to stick fields
	function automatic stick_t joy_to_stick(joy_t joy);
		stick_t s;
		s.up    = joy[JOY_UP];
		s.down  = joy[JOY_DOWN];
		s.left  = joy[JOY_LEFT];
		s.right = joy[JOY_RIGHT];
		s.fire  = joy[JOY_FIRE];
		s.warp  = joy[JOY_WARP];
		return s;
	endfunction

	assign key_event = toggle_q != ps2_key[PS2_TOGGLE];
	assign pressed   = ps2_key[PS2_PRESSED];
	assign code      = ps2_key[7:0];

	// ====================================================================
	// Key decoder
	// ====================================================================
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q    <= 1'b0;
			key_stick   <= '0;
			key_start1  <= 1'b0;
			key_start2  <= 1'b0;
			key_coin1   <= 1'b0;
			key_coin2   <= 1'b0;
			key_service <= 1'b0;
		end else begin
			toggle_q <= ps2_key[PS2_TOGGLE];
			// Each event sets the level of its key to the pressed bit
			if (key_event) begin
				case (code)
					KEY_START1:  key_start1      <= pressed;
					KEY_START2:  key_start2      <= pressed;
					KEY_COIN1:   key_coin1       <= pressed;
					KEY_COIN2:   key_coin2       <= pressed;
					KEY_SERVICE: key_service     <= pressed;
					KEY_UP:      key_stick.up    <= pressed;
					KEY_DOWN:    key_stick.down  <= pressed;
					KEY_LEFT:    key_stick.left  <= pressed;
					KEY_RIGHT:   key_stick.right <= pressed;
					KEY_FIRE:    key_stick.fire  <= pressed;
					KEY_WARP:    key_stick.warp  <= pressed;
					// Unknown codes leave every button alone
					default: ;
				endcase
			end
		end
	end

	// ====================================================================
	// Cabinet merge
	// ====================================================================
	// Keyboard arrows drive both players
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			cabinet <= '1;
		end else begin
			cabinet.coin    <= ~{key_coin2, key_coin1 | joystick_0[JOY_SELECT]};
			cabinet.start   <= ~{key_start2 | joystick_0[JOY_R],
				key_start1 | joystick_0[JOY_START]};
			cabinet.p1      <= ~(key_stick | joy_to_stick(joystick_0));
			cabinet.p2      <= ~(key_stick | joy_to_stick(joystick_1));
			cabinet.service <= ~key_service;
		end
	end

	// No X reaches the core once out of reset
	a_cabinet_known: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!$isunknown(cabinet));

endmodule

// ==== source/pll_underclock_seq.sv ====
// PLL underclock sequencer: tracks the speed request and writes the PLL management port
module pll_underclock_seq (
	input  logic             CLK_49M,
	input  logic             rst_n,
	input  logic             underclock,
	input  logic             waitrequest,
	output jf_pkg::pll_cfg_t cfg
);
	import jf_pkg::*;

	// Request synchroniser
	logic sync_q1;
	logic sync_q2;
	// Mode the PLL is being set to, low for native speed
	logic mode_q;
	logic settled_change;
	seq_state_t state;

	// Both stages agree on a value other than the latched one
	assign settled_change = (sync_q1 == sync_q2) && (sync_q2 != mode_q);

	// ====================================================================
	// Step sequencer
	// ====================================================================
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			mode_q  <= 1'b0;
			state   <= SEQ_IDLE;
		end else begin
			sync_q1 <= underclock;
			sync_q2 <= sync_q1;
			if (settled_change) begin
				// Restarts even in the middle of a sequence
				mode_q <= sync_q2;
				state  <= SEQ_MODE;
			end else if (!waitrequest && (state != SEQ_IDLE)) begin
				// Wraps from step 7 back to idle
				state <= seq_state_t'(state + 3'd1);
			end
		end
	end

	// Write decode
	// The step only moves on a free cycle so each write is a single pulse
	always_comb begin
		cfg = '0;
		if (!waitrequest) begin
			case (state)
				SEQ_MODE: begin
					cfg.write   = 1'b1;
					cfg.address = PLL_ADDR_MODE;
				end
				SEQ_MVAL: begin
					cfg.write   = 1'b1;
					cfg.address = PLL_ADDR_M;
					cfg.data    = mode_q ? PLL_M_UNDER : PLL_M_NATIVE;
				end
				SEQ_START: begin
					cfg.write   = 1'b1;
					cfg.address = PLL_ADDR_START;
				end
				default: ;
			endcase
		end
	end

	a_no_write_stalled: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg.write |-> !waitrequest);
	a_no_write_idle: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		(state == SEQ_IDLE) |-> !cfg.write);

endmodule

// ==== source/video_output.sv ====
// Video output: PCB tone conversion, sync alignment and aspect ratio selection
module video_output (
	input  logic                CLK_49M,
	input  logic                rst_n,
	input  jf_pkg::core_video_t core_video,
	input  logic [1:0]          ar_sel,
	input  logic                horizontal,
	output jf_pkg::vga_t        vga,
	output logic [12:0]         video_arx,
	output logic [12:0]         video_ary
);
	import jf_pkg::*;

	// Weighted sum of the set bits of one channel
	function automatic chan8_t tone(chan5_t c);
		chan8_t t;
		t = '0;
		if (c[0]) t = t + COLOR_W0;
		if (c[1]) t = t + COLOR_W1;
		if (c[2]) t = t + COLOR_W2;
		if (c[3]) t = t + COLOR_W3;
		if (c[4]) t = t + COLOR_W4;
		return t;
	endfunction

	// ====================================================================
	// Colour and timing stage
	// ====================================================================
	// Sync and blank share the colour register so all stay aligned
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			vga <= '0;
		end else begin
			vga.r      <= tone(core_video.r);
			vga.g      <= tone(core_video.g);
			vga.b      <= tone(core_video.b);
			vga.hs     <= core_video.hs;
			vga.vs     <= core_video.vs;
			vga.hblank <= core_video.hblank;
			vga.vblank <= core_video.vblank;
		end
	end

	// Native ratio swaps with orientation
	// Other settings pass the ARC index to the scaler
	always_comb begin
		if (ar_sel == 2'd0) begin
			video_arx = horizontal ? {1'b0, AR_NATIVE_H} : {1'b0, AR_NATIVE_W};
			video_ary = horizontal ? {1'b0, AR_NATIVE_W} : {1'b0, AR_NATIVE_H};
		end else begin
			video_arx = {11'd0, ar_sel - 2'd1};
			video_ary = '0;
		end
	end

	// Full-scale input gives full-scale output next cycle
	a_full_red: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		(core_video.r == 5'h1F) |=> (vga.r == 8'hFF));
	a_full_blue: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		(core_video.b == 5'h1F) |=> (vga.b == 8'hFF));

endmodule

// ==== tb/jf_io_model.svh ====
// Reference model of the Juno First I/O glue, stepped once per rising clock edge
`ifndef JF_IO_MODEL_SVH
`define JF_IO_MODEL_SVH

// Button level per scancode, high while held
logic [255:0] m_key;
logic         m_toggle;
cabinet_t     m_cab;
// Raw downloaded DIP bytes, byte 1 on top
logic [15:0]  m_dip;
vga_t         m_vga;
// Synchroniser stages, bit 0 is the first one
logic [1:0]   m_sync;
logic         m_mode;
int           m_step;

// PCB tone weights 19h, 24h, 35h, 40h and 4Dh for bits 0 to 4
function automatic chan8_t tone_of(chan5_t c);
	return ({8{c[0]}} & 8'h19) + ({8{c[1]}} & 8'h24) + ({8{c[2]}} & 8'h35)
		+ ({8{c[3]}} & 8'h40) + ({8{c[4]}} & 8'h4D);
endfunction

// Active-low stick from the arrow, ctrl and alt keys plus one joystick
function automatic stick_t stick_of(logic [255:0] k, joy_t j);
	stick_t s;
	s.up    = ~(k[8'h75] | j[3]);
	s.down  = ~(k[8'h72] | j[2]);
	s.left  = ~(k[8'h6B] | j[1]);
	s.right = ~(k[8'h74] | j[0]);
	s.fire  = ~(k[8'h14] | j[4]);
	s.warp  = ~(k[8'h11] | j[5]);
	return s;
endfunction

function automatic cabinet_t cabinet_of(logic [255:0] k, joy_t j0, joy_t j1);
	cabinet_t c;
	// Coin 1 also from select, start 1 from start, start 2 from R
	c.coin    = ~{k[8'h36], k[8'h2E] | j0[8]};
	c.start   = ~{k[8'h1E] | j0[7], k[8'h16] | j0[6]};
	c.p1      = stick_of(k, j0);
	c.p2      = stick_of(k, j1);
	c.service = ~k[8'h46];
	return c;
endfunction

// Native 14 by 16, swapped when horizontal, else ARC index and zero
function automatic logic [25:0] aspect_of(logic [2:0] st);
	if (st[2:1] == 2'd0) begin
		return st[0] ? {13'd16, 13'd14} : {13'd14, 13'd16};
	end
	return {11'd0, st[2:1] - 2'd1, 13'd0};
endfunction

// Management write seen in a cycle with the given step and stall level
function automatic pll_cfg_t pll_expect(int step, logic mode, logic stall);
	pll_cfg_t c;
	c = '0;
	if (!stall && (step == 1 || step == 5 || step == 7)) begin
		c.write   = 1'b1;
		c.address = (step == 1) ? 6'd0 : ((step == 5) ? 6'd7 : 6'd2);
		if (step == 5) begin
			c.data = mode ? 32'd3268298314 : 32'd3639383488;
		end
	end
	return c;
endfunction

task automatic model_reset();
	m_key    = '0;
	m_toggle = 1'b0;
	m_cab    = '1;
	m_dip    = '0;
	m_vga    = '0;
	m_sync   = 2'b00;
	m_mode   = 1'b0;
	m_step   = 0;
endtask

// One rising edge with the inputs that are applied now
task automatic model_clock();
	if (!rst_n) begin
		model_reset();
	end else begin
		// Cabinet register sees the key levels from before this edge
		m_cab = cabinet_of(m_key, joystick_0, joystick_1);
		if (ps2_key[10] != m_toggle) begin
			m_key[ps2_key[7:0]] = ps2_key[9];
		end
		m_toggle = ps2_key[10];
		if (ioctl.wr && ioctl.index == 8'd254 && ioctl.addr < 25'd2) begin
			if (ioctl.addr[0]) begin
				m_dip[15:8] = ioctl.dout;
			end else begin
				m_dip[7:0] = ioctl.dout;
			end
		end
		m_vga = {tone_of(core_video.r), tone_of(core_video.g), tone_of(core_video.b),
			core_video.hs, core_video.vs, core_video.hblank, core_video.vblank};
		// A settled change restarts the write sequence at step 1
		if (m_sync[1] == m_sync[0] && m_sync[1] != m_mode) begin
			m_mode = m_sync[1];
			m_step = 1;
		end else if (!pll_waitrequest && m_step != 0) begin
			m_step = (m_step + 1) % 8;
		end
		m_sync = {m_sync[0], status[21]};
	end
endtask

`endif

// ==== tb/tb_jf_io.sv ====
// Testbench for the Juno First I/O glue with random stimulus checked against a cycle model
module tb_jf_io;
	timeunit 1ns;
	timeprecision 1ps;
	import jf_pkg::*;

	// Tests take about 1200 cycles
	localparam int RANDOM_CYCLES = 1000;
	localparam int PLL_TRIALS    = 6;
	localparam int MAX_CYCLES    = 2000;
	// Keys 1 2 5 6 9 P, arrows, ctrl and alt
	localparam logic [7:0] KEY_CODES [12] = '{8'h16, 8'h1E, 8'h2E, 8'h36, 8'h46, 8'h4D,
		8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11};

	logic        CLK_49M;
	logic        rst_n;
	ps2_key_t    ps2_key;
	joy_t        joystick_0;
	joy_t        joystick_1;
	ioctl_t      ioctl;
	status_t     status;
	core_video_t core_video;
	logic        pll_waitrequest;
	cabinet_t    cabinet;
	dip_t        dip_sw;
	vga_t        vga;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	pll_cfg_t    pll_cfg;

	integer   seed;
	int       cycles;
	// Underclock request held on status bit 21
	logic     uc_req;
	pll_cfg_t writes [$];

	`include "jf_io_model.svh"

	jf_io_top dut_i (
		.CLK_49M         (CLK_49M),
		.rst_n           (rst_n),
		.ps2_key         (ps2_key),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.ioctl           (ioctl),
		.status          (status),
		.core_video      (core_video),
		.pll_waitrequest (pll_waitrequest),
		.cabinet         (cabinet),
		.dip_sw          (dip_sw),
		.vga             (vga),
		.video_arx       (video_arx),
		.video_ary       (video_ary),
		.pll_cfg         (pll_cfg)
	);

	always #10 CLK_49M = ~CLK_49M;

	// ====================================================================
	// Run limit
	// ====================================================================
	always @(posedge CLK_49M) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1, "run limit reached");
		end
	end

	task automatic fail_value(string what, logic [63:0] got, logic [63:0] exp);
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1, "wrong value on %s", what);
	endtask

	// Registered outputs against the model after the edge
	task automatic check_registered();
		dip_t exp_dip;
		exp_dip = ~m_dip;
		assert (cabinet === m_cab) else fail_value("cabinet", 64'(cabinet), 64'(m_cab));
		assert (dip_sw === exp_dip) else fail_value("dip_sw", 64'(dip_sw), 64'(exp_dip));
		assert (vga === m_vga) else fail_value("vga", 64'(vga), 64'(m_vga));
	endtask

	// Combinational outputs as the next edge will see them
	task automatic check_comb();
		pll_cfg_t    exp_cfg;
		logic [25:0] exp_ar;
		exp_cfg = pll_expect(m_step, m_mode, pll_waitrequest);
		exp_ar  = aspect_of(status[14:12]);
		assert ({video_arx, video_ary} === exp_ar)
			else fail_value("aspect", 64'({video_arx, video_ary}), 64'(exp_ar));
		assert (!(pll_cfg.write && pll_waitrequest))
			else fail_value("write during stall", 64'(pll_cfg), 64'(exp_cfg));
		assert (pll_cfg.write === exp_cfg.write)
			else fail_value("pll write", 64'(pll_cfg), 64'(exp_cfg));
		if (pll_cfg.write) begin
			assert (pll_cfg === exp_cfg)
				else fail_value("pll cfg", 64'(pll_cfg), 64'(exp_cfg));
			writes.push_back(pll_cfg);
		end
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	task automatic drive_inputs(int ar_combo);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0]  ki;
		rst_n = (cycles >= 2);
		r  = $random(seed);
		ki = 4'(r[31:8] % 24'd12);
		// Toggle flips on about half the cycles
		// Code changes either way
		ps2_key[10]  = ps2_key[10] ^ r[0];
		ps2_key[9]   = r[1];
		// One code in eight is a random byte and mostly unknown
		ps2_key[7:0] = (r[4:2] == 3'd0) ? r[15:8] : KEY_CODES[ki];
		r = $random(seed);
		w = $random(seed);
		// Sparse joystick words so keys still show through
		if (r[1:0] == 2'd0) joystick_0 = w[31:16] & w[15:0];
		if (r[3:2] == 2'd0) joystick_1 = w[15:0] & w[31:16] & r[31:16];
		r = $random(seed);
		ioctl.wr    = r[0];
		ioctl.index = r[1] ? 8'd254 : r[15:8];
		ioctl.addr  = r[2] ? {23'd0, r[4:3]} : {9'd0, r[31:16]};
		ioctl.dout  = r[12:5];
		r = $random(seed);
		core_video = r[18:0];
		if (r[31:29] == 3'd0) begin
			core_video.r = 5'h1F;
			core_video.g = 5'h1F;
			core_video.b = 5'h1F;
		end
		status     = $random(seed);
		status[21] = uc_req;
		if (ar_combo >= 0) status[14:12] = 3'(ar_combo);
		r = $random(seed);
		pll_waitrequest = r[0];
	endtask

	task automatic run_cycle(int ar_combo);
		@(negedge CLK_49M);
		model_clock();
		check_registered();
		drive_inputs(ar_combo);
		// Combinational outputs settle well before the next edge
		#2;
		check_comb();
	endtask

	task automatic check_one_write(string what, pll_cfg_t got, logic [5:0] addr,
		logic [31:0] data);
		assert (got.address === addr && got.data === data)
			else fail_value(what, 64'({got.address, got.data}), 64'({addr, data}));
	endtask

	initial begin
		seed            = 32'hbeca;
		cycles          = 0;
		uc_req          = 1'b0;
		CLK_49M         = 1'b0;
		rst_n           = 1'b0;
		ps2_key         = '0;
		joystick_0      = '0;
		joystick_1      = '0;
		ioctl           = '0;
		status          = '0;
		core_video      = '0;
		pll_waitrequest = 1'b0;
		model_reset();
		// All aspect settings with the first two under reset
		for (int a = 0; a < 8; a++) begin
			run_cycle(a);
		end
		repeat (RANDOM_CYCLES) run_cycle(-1);
		// Each trial flips the underclock request and collects the writes
		for (int t = 0; t < PLL_TRIALS; t++) begin
			writes.delete();
			uc_req = ~uc_req;
			while (writes.size() < 3) run_cycle(-1);
			repeat (12) run_cycle(-1);
			assert (writes.size() == 3)
				else fail_value("PLL write count", 64'(writes.size()), 64'd3);
			check_one_write("PLL write 1", writes[0], 6'd0, 32'd0);
			check_one_write("PLL write 2", writes[1], 6'd7,
				uc_req ? 32'd3268298314 : 32'd3639383488);
			check_one_write("PLL write 3", writes[2], 6'd2, 32'd0);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
